/* dtim_defs.svh */
`ifndef DTIM_DEFS_SVH
`define DTIM_DEFS_SVH

// Line store geometry.
`define DTIM_DEPTH 4  // Index bits, so the store holds 16 lines.
`define DTIM_WIDTH 2  // Log2 of the words in one line.

// Address window served by the line store.
`define DTIM_BASE 32'h0000_1000  // Lowest address inside the window.
`define DTIM_TOP 32'h0000_2000  // First address above the window.

`endif

/* dtim_pkg.sv */
`include "dtim_defs.svh"

package dtim_pkg;

  // Address bits left above the index, word and byte fields.
  typedef logic [29-`DTIM_DEPTH-`DTIM_WIDTH:0] tag_t;

  // One full line of the data array.
  typedef logic [32*(2**`DTIM_WIDTH)-1:0] line_t;

  typedef logic [31:0] word_t;

  typedef enum logic [2:0] {
    IDLE,       // Waits for a request and decides on it.
    FILL,       // Loads a whole line from backing memory.
    BYPASS,     // Single-word transfer on the backing bus.
    UPDATE,     // Returns the result of a store hit or a fill.
    FENCE,      // Visits one index per cycle.
    WRITEBACK   // Sends a locked line back word by word.
  } ctrl_state_t;

endpackage

/* dtim_array_if.sv */
`timescale 1ns/1ns
`include "dtim_defs.svh"

interface dtim_array_if #(
  parameter type payload_t = logic,
  parameter int ADDR_BITS = `DTIM_DEPTH
);

  logic wen;
  logic [ADDR_BITS-1:0] waddr;
  logic [ADDR_BITS-1:0] raddr;
  payload_t wdata;
  payload_t rdata;  // Valid one cycle after raddr is presented.

  modport ctrl (
    output wen, waddr, raddr, wdata,
    input rdata
  );

  modport array (
    input wen, waddr, raddr, wdata,
    output rdata
  );

endinterface

/* dtim_array.sv */
`timescale 1ns/1ns
`include "dtim_defs.svh"

module dtim_array #(
  parameter type payload_t = logic,
  parameter int ADDR_BITS = `DTIM_DEPTH
) (
  input logic clk,
  dtim_array_if.array port
);

  payload_t mem [2**ADDR_BITS];
  payload_t rdata_q;

  always_ff @(posedge clk) begin
    if (port.wen) begin
      mem[port.waddr] <= port.wdata;
    end
    rdata_q <= mem[port.raddr];  // A colliding write is seen one read later.
  end

  assign port.rdata = rdata_q;

endmodule

/* dtim_ctrl.sv */
`timescale 1ns/1ns
`include "dtim_defs.svh"

module dtim_ctrl (
  input logic clk,
  input logic rst,
  dtim_array_if.ctrl tag_port,
  dtim_array_if.ctrl data_port,
  dtim_array_if.ctrl lock_port,
  input logic cpu_valid,
  input logic cpu_fence,
  input dtim_pkg::word_t cpu_addr,
  input dtim_pkg::word_t cpu_wdata,
  input logic [3:0] cpu_wstrb,
  output logic cpu_ready,
  output dtim_pkg::word_t cpu_rdata,
  output logic mem_valid,
  output dtim_pkg::word_t mem_addr,
  output dtim_pkg::word_t mem_wdata,
  output logic [3:0] mem_wstrb,
  input logic mem_ready,
  input dtim_pkg::word_t mem_rdata
);

  localparam int word_lsb = 2;
  localparam int index_lsb = `DTIM_WIDTH + 2;
  localparam int tag_lsb = `DTIM_DEPTH + `DTIM_WIDTH + 2;

  dtim_pkg::ctrl_state_t state_q;
  dtim_pkg::ctrl_state_t state_d;
  logic req_q;
  logic fence_q;
  dtim_pkg::word_t addr_q;
  dtim_pkg::word_t wdata_q;
  logic [3:0] strb_q;
  logic [`DTIM_WIDTH-1:0] wid_q;
  dtim_pkg::tag_t tag_q;
  dtim_pkg::tag_t tag_d;
  logic [`DTIM_DEPTH-1:0] idx_q;
  logic [`DTIM_DEPTH-1:0] idx_d;
  logic [`DTIM_WIDTH-1:0] cnt_q;
  logic [`DTIM_WIDTH-1:0] cnt_d;
  dtim_pkg::line_t line_q;
  dtim_pkg::line_t line_d;
  dtim_pkg::line_t fill_line;
  logic store;
  logic in_window;
  logic tag_match;

  // Writes the strobed bytes of one word into a line.
  function automatic dtim_pkg::line_t merge_word(
    input dtim_pkg::line_t line,
    input logic [`DTIM_WIDTH-1:0] wid,
    input dtim_pkg::word_t data,
    input logic [3:0] strb
  );
    dtim_pkg::line_t result;
    result = line;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[32*wid + 8*b +: 8] = data[8*b +: 8];
      end
    end
    return result;
  endfunction

  assign store = |strb_q;
  assign in_window = (addr_q >= `DTIM_BASE) && (addr_q < `DTIM_TOP);
  assign tag_match = tag_port.rdata == tag_q;

  always_comb begin
    fill_line = line_q;
    fill_line[32*cnt_q +: 32] = mem_rdata;
  end

  always_comb begin
    state_d = state_q;
    idx_d = idx_q;
    cnt_d = cnt_q;
    tag_d = tag_q;
    line_d = line_q;
    cpu_ready = 1'b0;
    tag_port.wen = 1'b0;
    data_port.wen = 1'b0;
    lock_port.wen = 1'b0;
    if (cpu_valid) begin
      idx_d = cpu_fence ? '0 : cpu_addr[tag_lsb-1:index_lsb];  // A fence starts at index 0.
      tag_d = cpu_addr[31:tag_lsb];
    end
    case (state_q)
      dtim_pkg::IDLE: begin
        if (req_q) begin
          cnt_d = '0;
          if (fence_q) begin
            state_d = dtim_pkg::FENCE;
          end else if (!in_window) begin
            state_d = dtim_pkg::BYPASS;
          end else if (!lock_port.rdata) begin
            state_d = dtim_pkg::FILL;
          end else if (!tag_match) begin
            state_d = dtim_pkg::BYPASS;  // Index is held by another tag.
          end else if (store) begin
            line_d = merge_word(data_port.rdata, wid_q, wdata_q, strb_q);
            data_port.wen = 1'b1;
            state_d = dtim_pkg::UPDATE;
          end else begin
            cpu_ready = 1'b1;
          end
        end
      end
      dtim_pkg::FILL: begin
        if (mem_ready) begin
          // A zero strobe leaves the line as it came from memory.
          line_d = merge_word(fill_line, wid_q, wdata_q, strb_q);
          if (&cnt_q) begin
            tag_port.wen = 1'b1;
            data_port.wen = 1'b1;
            lock_port.wen = 1'b1;
            state_d = dtim_pkg::UPDATE;
          end else begin
            cnt_d = cnt_q + 1'b1;
          end
        end
      end
      dtim_pkg::BYPASS: begin
        if (mem_ready) begin
          cpu_ready = 1'b1;
          state_d = dtim_pkg::IDLE;
        end
      end
      dtim_pkg::UPDATE: begin
        cpu_ready = 1'b1;
        state_d = dtim_pkg::IDLE;
      end
      dtim_pkg::FENCE: begin
        if (lock_port.rdata) begin
          tag_d = tag_port.rdata;  // Tag and line of the resident entry for write-back.
          line_d = data_port.rdata;
          cnt_d = '0;
          state_d = dtim_pkg::WRITEBACK;
        end else if (&idx_q) begin
          cpu_ready = 1'b1;
          state_d = dtim_pkg::IDLE;
        end else begin
          idx_d = idx_q + 1'b1;
        end
      end
      dtim_pkg::WRITEBACK: begin
        if (mem_ready) begin
          if (&cnt_q) begin
            lock_port.wen = 1'b1;  // Unlocks the index.
            cnt_d = '0;
            if (&idx_q) begin
              cpu_ready = 1'b1;
              state_d = dtim_pkg::IDLE;
            end else begin
              idx_d = idx_q + 1'b1;
              state_d = dtim_pkg::FENCE;
            end
          end else begin
            cnt_d = cnt_q + 1'b1;
          end
        end
      end
      default: begin
        state_d = dtim_pkg::IDLE;
      end
    endcase
  end

  // The arrays read the next index so their data lines up with the state.
  assign tag_port.raddr = idx_d;
  assign data_port.raddr = idx_d;
  assign lock_port.raddr = idx_d;
  assign tag_port.waddr = idx_q;
  assign data_port.waddr = idx_q;
  assign lock_port.waddr = idx_q;
  assign tag_port.wdata = tag_q;
  assign data_port.wdata = line_d;
  assign lock_port.wdata = state_q == dtim_pkg::FILL;

  always_ff @(posedge clk) begin
    if (!rst) begin
      state_q <= dtim_pkg::IDLE;
      req_q <= 1'b0;
      fence_q <= 1'b0;
      idx_q <= '0;
      cnt_q <= '0;
    end else begin
      state_q <= state_d;
      req_q <= cpu_valid;  // Decision is made in the cycle after capture.
      fence_q <= cpu_valid & cpu_fence;
      idx_q <= idx_d;
      cnt_q <= cnt_d;
    end
  end

  always_ff @(posedge clk) begin
    if (cpu_valid) begin
      addr_q <= cpu_addr;
      wdata_q <= cpu_wdata;
      strb_q <= cpu_wstrb;
      wid_q <= cpu_addr[index_lsb-1:word_lsb];
    end
    tag_q <= tag_d;
    line_q <= line_d;
  end

  assign mem_valid = state_q inside {dtim_pkg::FILL, dtim_pkg::BYPASS, dtim_pkg::WRITEBACK};
  assign mem_addr = (state_q == dtim_pkg::BYPASS) ? addr_q : {tag_q, idx_q, cnt_q, 2'b00};
  assign mem_wdata = (state_q == dtim_pkg::WRITEBACK) ? line_q[32*cnt_q +: 32] : wdata_q;
  assign mem_wstrb = (state_q == dtim_pkg::WRITEBACK) ? 4'hf :
                     (state_q == dtim_pkg::BYPASS) ? strb_q : 4'h0;

  always_comb begin
    case (state_q)
      dtim_pkg::IDLE: cpu_rdata = data_port.rdata[32*wid_q +: 32];
      dtim_pkg::BYPASS: cpu_rdata = mem_rdata;
      dtim_pkg::UPDATE: cpu_rdata = line_q[32*wid_q +: 32];
      default: cpu_rdata = '0;
    endcase
  end

endmodule

/* dtim.sv */
`timescale 1ns/1ns
`include "dtim_defs.svh"

module dtim (
  input logic clk,
  input logic rst,
  input logic cpu_valid,
  input logic cpu_fence,
  input dtim_pkg::word_t cpu_addr,
  input dtim_pkg::word_t cpu_wdata,
  input logic [3:0] cpu_wstrb,
  output logic cpu_ready,
  output dtim_pkg::word_t cpu_rdata,
  output logic mem_valid,
  output dtim_pkg::word_t mem_addr,
  output dtim_pkg::word_t mem_wdata,
  output logic [3:0] mem_wstrb,
  input logic mem_ready,
  input dtim_pkg::word_t mem_rdata
);

  dtim_array_if #(
    .payload_t (dtim_pkg::tag_t),
    .ADDR_BITS (`DTIM_DEPTH)
  ) tag_if ();

  dtim_array_if #(
    .payload_t (dtim_pkg::line_t),
    .ADDR_BITS (`DTIM_DEPTH)
  ) data_if ();

  // One bit per index marks a resident line.
  dtim_array_if #(
    .payload_t (logic),
    .ADDR_BITS (`DTIM_DEPTH)
  ) lock_if ();

  dtim_array #(
    .payload_t (dtim_pkg::tag_t),
    .ADDR_BITS (`DTIM_DEPTH)
  ) tag_array (
    .clk  (clk),
    .port (tag_if.array)
  );

  dtim_array #(
    .payload_t (dtim_pkg::line_t),
    .ADDR_BITS (`DTIM_DEPTH)
  ) data_array (
    .clk  (clk),
    .port (data_if.array)
  );

  dtim_array #(
    .payload_t (logic),
    .ADDR_BITS (`DTIM_DEPTH)
  ) lock_array (
    .clk  (clk),
    .port (lock_if.array)
  );

  dtim_ctrl ctrl (
    .clk       (clk),
    .rst       (rst),
    .tag_port  (tag_if.ctrl),
    .data_port (data_if.ctrl),
    .lock_port (lock_if.ctrl),
    .cpu_valid (cpu_valid),
    .cpu_fence (cpu_fence),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .cpu_wstrb (cpu_wstrb),
    .cpu_ready (cpu_ready),
    .cpu_rdata (cpu_rdata),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata)
  );

endmodule

/* dtim_tb_mem.sv */
`timescale 1ns/1ns

module dtim_tb_mem (
  input logic clk,
  input logic rst,
  input logic mem_valid,
  input dtim_pkg::word_t mem_addr,
  input dtim_pkg::word_t mem_wdata,
  input logic [3:0] mem_wstrb,
  output logic mem_ready,
  output dtim_pkg::word_t mem_rdata
);

  dtim_pkg::word_t shadow [dtim_pkg::word_t];
  int transfers;
  int valid_cycles;
  dtim_pkg::word_t last_addr;
  dtim_pkg::word_t last_wdata;
  logic [3:0] last_wstrb;
  logic [15:0] lfsr;
  logic [1:0] delay;
  logic [1:0] draw;
  dtim_pkg::word_t merged;

  // Contents of a word that was never written.
  function automatic dtim_pkg::word_t pattern_word(input dtim_pkg::word_t a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
  endfunction

  function automatic dtim_pkg::word_t read_word(input dtim_pkg::word_t a);
    dtim_pkg::word_t wa;
    wa = {a[31:2], 2'b00};
    if (shadow.exists(wa)) begin
      return shadow[wa];
    end
    return pattern_word(wa);
  endfunction

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // Taps 16, 14, 13 and 11.
  endfunction

  initial begin
    lfsr = 16'd55369;
    transfers = 0;
    valid_cycles = 0;
    mem_ready = 1'b0;
    mem_rdata = '0;
    delay = 2'd0;
  end

  always @(posedge clk) begin
    if (mem_valid) begin
      valid_cycles <= valid_cycles + 1;  // Every cycle the bus is requested.
    end
  end

  always @(posedge clk) begin
    if (!rst) begin
      mem_ready <= 1'b0;
      delay <= 2'd0;
    end else if (mem_ready) begin
      if (mem_wstrb != 4'h0) begin
        merged = read_word(mem_addr);
        for (int b = 0; b < 4; b++) begin
          if (mem_wstrb[b]) begin
            merged[8*b +: 8] = mem_wdata[8*b +: 8];
          end
        end
        shadow[{mem_addr[31:2], 2'b00}] = merged;
        last_addr <= mem_addr;
        last_wdata <= mem_wdata;
        last_wstrb <= mem_wstrb;
      end
      transfers <= transfers + 1;
      mem_ready <= 1'b0;
      lfsr = lfsr_next(lfsr);
      draw[0] = lfsr[0];
      lfsr = lfsr_next(lfsr);
      draw[1] = lfsr[0];
      delay <= draw;  // Wait states before the next word.
    end else if (mem_valid) begin
      if (delay == 2'd0) begin
        mem_ready <= 1'b1;
        mem_rdata <= read_word(mem_addr);
      end else begin
        delay <= delay - 2'd1;
      end
    end
  end

endmodule

/* dtim_tb.sv */
`timescale 1ns/1ns

module dtim_tb;

  logic clk;
  logic rst;
  logic cpu_valid;
  logic cpu_fence;
  dtim_pkg::word_t cpu_addr;
  dtim_pkg::word_t cpu_wdata;
  logic [3:0] cpu_wstrb;
  logic cpu_ready;
  dtim_pkg::word_t cpu_rdata;
  logic mem_valid;
  dtim_pkg::word_t mem_addr;
  dtim_pkg::word_t mem_wdata;
  logic [3:0] mem_wstrb;
  logic mem_ready;
  dtim_pkg::word_t mem_rdata;

  dtim_pkg::word_t model [dtim_pkg::word_t];
  logic [15:0] lfsr;
  int checks;
  int errors;
  int timeouts;
  int latency;
  int n0;
  dtim_pkg::word_t rdata_seen;
  dtim_pkg::word_t r_region;
  dtim_pkg::word_t r_idx;
  dtim_pkg::word_t r_word;
  dtim_pkg::word_t r_op;
  dtim_pkg::word_t r_strb;
  dtim_pkg::word_t r_data;
  dtim_pkg::word_t base;
  dtim_pkg::word_t addr;

  dtim dut (.*);

  dtim_tb_mem mem_model (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic dtim_pkg::word_t pattern_word(input dtim_pkg::word_t a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
  endfunction

  // Expected load value from the model of memory.
  function automatic dtim_pkg::word_t expected_load(input dtim_pkg::word_t a);
    dtim_pkg::word_t wa;
    wa = {a[31:2], 2'b00};
    if (model.exists(wa)) begin
      return model[wa];
    end
    return pattern_word(wa);
  endfunction

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output dtim_pkg::word_t v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check_value(input string name, input dtim_pkg::word_t exp,
                             input dtim_pkg::word_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  // One request pulse, then a bounded wait for cpu_ready.
  task automatic access(input logic fence, input dtim_pkg::word_t a,
                        input dtim_pkg::word_t d, input logic [3:0] s);
    if (timeouts > 0) begin
      return;
    end
    @(posedge clk);
    cpu_valid <= 1'b1;
    cpu_fence <= fence;
    cpu_addr <= a;
    cpu_wdata <= d;
    cpu_wstrb <= s;
    @(negedge clk);
    @(posedge clk);
    cpu_valid <= 1'b0;
    cpu_fence <= 1'b0;
    latency = 1;
    do begin
      @(negedge clk);
      latency++;
    end while (!cpu_ready && latency < 2000);
    if (!cpu_ready) begin
      timeouts++;
      $display("Timeout: no cpu_ready for the request to address %h", a);
    end else begin
      rdata_seen = cpu_rdata;
      @(negedge clk);  // A backing word completes on the edge after its mem_ready cycle.
    end
  endtask

  task automatic load(input string name, input dtim_pkg::word_t a);
    access(1'b0, a, '0, 4'h0);
    if (timeouts == 0) begin
      check_value(name, expected_load(a), rdata_seen);
    end
  endtask

  task automatic store(input dtim_pkg::word_t a, input dtim_pkg::word_t d,
                       input logic [3:0] s);
    dtim_pkg::word_t w;
    access(1'b0, a, d, s);
    w = expected_load(a);
    for (int b = 0; b < 4; b++) begin
      if (s[b]) begin
        w[8*b +: 8] = d[8*b +: 8];
      end
    end
    model[{a[31:2], 2'b00}] = w;
  endtask

  initial begin
    rst = 1'b0;
    cpu_valid = 1'b0;
    cpu_fence = 1'b0;
    cpu_addr = '0;
    cpu_wdata = '0;
    cpu_wstrb = 4'h0;
    lfsr = 16'd55369;
    checks = 0;
    errors = 0;
    timeouts = 0;
    repeat (3) @(posedge clk);
    rst <= 1'b1;
    access(1'b1, '0, '0, 4'h0);  // Clears the lock array.

    load("fill_load", 32'h0000_1040);
    n0 = mem_model.valid_cycles;
    load("hit_load", 32'h0000_1048);
    check_value("hit_no_backing", n0, mem_model.valid_cycles);
    check_value("hit_latency", 2, latency);

    n0 = mem_model.transfers;
    store(32'h0000_1044, 32'hdead_beef, 4'b0101);
    store(32'h0000_104c, 32'h1234_5678, 4'b1000);
    load("merge_load_1", 32'h0000_1044);
    load("merge_load_3", 32'h0000_104c);
    load("merge_load_0", 32'h0000_1040);
    check_value("merge_no_backing", n0, mem_model.transfers);

    n0 = mem_model.transfers;
    load("conflict_load", 32'h0000_1144);
    check_value("conflict_load_xfers", n0 + 1, mem_model.transfers);
    store(32'h0000_1148, 32'hcafe_f00d, 4'b0011);
    check_value("conflict_store_xfers", n0 + 2, mem_model.transfers);
    check_value("conflict_wstrb", 32'h3, {28'd0, mem_model.last_wstrb});
    check_value("conflict_wdata", 32'hcafe_f00d, mem_model.last_wdata);
    check_value("conflict_addr", 32'h0000_1148, mem_model.last_addr);
    load("conflict_reload", 32'h0000_1148);

    store(32'h0000_0ffc, 32'h0bad_cafe, 4'b1110);
    load("below_load", 32'h0000_0ffc);
    store(32'h0000_2000, 32'h7777_1111, 4'b1111);
    load("above_load", 32'h0000_2000);
    load("above_pattern", 32'h0000_2ff4);

    access(1'b1, '0, '0, 4'h0);
    check_value("fence_word_1", model[32'h0000_1044], mem_model.shadow[32'h0000_1044]);
    check_value("fence_word_3", model[32'h0000_104c], mem_model.shadow[32'h0000_104c]);
    n0 = mem_model.transfers;
    load("refill_load", 32'h0000_1044);
    check_value("refill_xfers", n0 + 4, mem_model.transfers);

    for (int i = 0; i < 200; i++) begin
      take_bits(2, r_region);
      take_bits(4, r_idx);
      take_bits(2, r_word);
      take_bits(1, r_op);
      take_bits(4, r_strb);
      take_bits(32, r_data);
      case (r_region[1:0])
        2'd0: base = 32'h0000_1000;
        2'd1: base = 32'h0000_1100;
        2'd2: base = 32'h0000_0f00;
        default: base = 32'h0000_2000;
      endcase
      addr = base + {24'd0, r_idx[3:0], r_word[1:0], 2'b00};
      if (r_op[0]) begin
        store(addr, r_data, (r_strb[3:0] == 4'h0) ? 4'hf : r_strb[3:0]);
      end else begin
        load("random_load", addr);
      end
    end
    access(1'b1, '0, '0, 4'h0);
    foreach (model[a]) begin
      check_value("final_shadow", model[a], mem_model.shadow[a]);
    end

    $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* dtim.f */
+incdir+.
dtim_pkg.sv
dtim_array_if.sv
dtim_array.sv
dtim_ctrl.sv
dtim.sv
dtim_tb_mem.sv
dtim_tb.sv

/* Makefile */
SIM = obj_dir/dtim_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f dtim.f --top-module dtim_tb -o dtim_sim

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
